// ==== logic/bft_leaf_pkg.sv ====
`default_nettype none

package bft_leaf_pkg;

    localparam int packet_bits = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits = 5;
    localparam int port_bits = 4;
    localparam int addr_bits = 7;

    localparam int num_in_ports = 6;
    localparam int num_out_ports = 4;
    localparam int sel_bits = $clog2(num_out_ports);

    // Port 0 of every leaf is reserved for configuration packets.
    localparam logic [port_bits-1:0] cfg_port = '0;

    typedef struct packed {
        logic [payload_bits-sel_bits-leaf_bits-port_bits-1:0] rsvd;
        logic [sel_bits-1:0] out_sel;
        logic [leaf_bits-1:0] route_leaf;
        logic [port_bits-1:0] route_port;
    } cfg_body_t;

    // The same 32 bits are a user word or a route setting, depending on dest_port.
    typedef union packed {
        logic [payload_bits-1:0] data;
        cfg_body_t cfg;
    } packet_body_u;

    typedef struct packed {
        logic valid;
        logic [leaf_bits-1:0] dest_leaf;
        logic [port_bits-1:0] dest_port;
        logic [addr_bits-1:0] addr;
        packet_body_u body;
    } packet_t;

    typedef struct packed {
        logic [leaf_bits-1:0] leaf;
        logic [port_bits-1:0] port;
    } route_t;

    typedef struct packed {
        logic wr;
        logic [sel_bits-1:0] out_sel;
        route_t route;
    } route_wr_t;

    typedef struct packed {
        logic vld;
        logic [payload_bits-1:0] data;
    } port_word_t;

endpackage

`default_nettype wire

// ==== logic/leaf_rx_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module leaf_rx_decode #(
    parameter logic [bft_leaf_pkg::leaf_bits-1:0] LEAF_ID = 2
) (
    input  logic                                                     clk_400,
    input  logic                                                     rst,
    input  bft_leaf_pkg::packet_t                                    din,
    output bft_leaf_pkg::port_word_t [bft_leaf_pkg::num_in_ports-1:0] port_words,
    output bft_leaf_pkg::route_wr_t                                  route_wr
);

    localparam int n_in = bft_leaf_pkg::num_in_ports;

    logic hit;
    logic is_cfg;
    logic [n_in-1:0] port_hit;
    logic [n_in-1:0] word_vld;
    logic [bft_leaf_pkg::payload_bits-1:0] word_data;
    logic cfg_wr;
    bft_leaf_pkg::cfg_body_t cfg_q;

    // Only packets addressed to this leaf are kept.
    assign hit = din.valid && (din.dest_leaf == LEAF_ID);
    assign is_cfg = (din.dest_port == bft_leaf_pkg::cfg_port);

    // Data ports are numbered from 1, so port i+1 feeds buffer i.
    // Ports above the last input port match nothing and are dropped.
    always_comb begin
        for (int i = 0; i < n_in; i++) begin
            port_hit[i] = hit && (int'(din.dest_port) == i + 1);
        end
    end

    always_ff @(posedge clk_400) begin
        if (rst) begin
            word_vld <= '0;
            cfg_wr <= 1'b0;
        end else begin
            word_vld <= port_hit;
            cfg_wr <= hit && is_cfg;
        end
    end

    always_ff @(posedge clk_400) begin
        if (hit) begin
            word_data <= din.body.data;
            cfg_q <= din.body.cfg;
        end
    end

    // All ports see the same word; only the strobed one takes it.
    always_comb begin
        for (int i = 0; i < n_in; i++) begin
            port_words[i].vld = word_vld[i];
            port_words[i].data = word_data;
        end
        route_wr.wr = cfg_wr;
        route_wr.out_sel = cfg_q.out_sel;
        route_wr.route.leaf = cfg_q.route_leaf;
        route_wr.route.port = cfg_q.route_port;
    end

endmodule

`default_nettype wire

// ==== logic/leaf_in_ports.sv ====
`default_nettype none
`timescale 1ns/1ps

module leaf_in_ports (
    input  logic                                                     clk_400,
    input  logic                                                     rst,
    input  bft_leaf_pkg::port_word_t [bft_leaf_pkg::num_in_ports-1:0] port_words,
    output logic [bft_leaf_pkg::num_in_ports-1:0][bft_leaf_pkg::payload_bits-1:0] in_data,
    output logic [bft_leaf_pkg::num_in_ports-1:0]                    in_vld,
    input  logic [bft_leaf_pkg::num_in_ports-1:0]                    in_ack
);

    localparam int n_in = bft_leaf_pkg::num_in_ports;

    logic [n_in-1:0] full;
    logic [n_in-1:0][bft_leaf_pkg::payload_bits-1:0] word_q;

    // A new word wins over an ack in the same cycle, so the buffer stays full.
    always_ff @(posedge clk_400) begin
        if (rst) begin
            full <= '0;
        end else begin
            for (int i = 0; i < n_in; i++) begin
                if (port_words[i].vld) begin
                    full[i] <= 1'b1;
                end else if (in_ack[i]) begin
                    full[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_400) begin
        for (int i = 0; i < n_in; i++) begin
            if (port_words[i].vld) begin
                word_q[i] <= port_words[i].data;
            end
        end
    end

    assign in_vld = full;
    assign in_data = word_q;

endmodule

`default_nettype wire

// ==== logic/leaf_user_kernel.sv ====
`default_nettype none
`timescale 1ns/1ps

module leaf_user_kernel (
    input  logic                                                                   clk_400,
    input  logic                                                                   rst,
    input  logic [bft_leaf_pkg::num_in_ports-1:0][bft_leaf_pkg::payload_bits-1:0]  in_data,
    input  logic [bft_leaf_pkg::num_in_ports-1:0]                                  in_vld,
    output logic [bft_leaf_pkg::num_in_ports-1:0]                                  in_ack,
    output logic [bft_leaf_pkg::num_out_ports-1:0][bft_leaf_pkg::payload_bits-1:0] out_data,
    output logic [bft_leaf_pkg::num_out_ports-1:0]                                 out_vld,
    input  logic [bft_leaf_pkg::num_out_ports-1:0]                                 out_ack
);

    localparam int n_in = bft_leaf_pkg::num_in_ports;
    localparam int n_out = bft_leaf_pkg::num_out_ports;

    // Inputs used by each result, result 0 in the lowest entry.
    localparam logic [n_out-1:0][n_in-1:0] need = {
        6'b100001, 6'b110000, 6'b001100, 6'b000011
    };

    logic [n_out-1:0][bft_leaf_pkg::payload_bits-1:0] res_next;
    logic [n_out-1:0][bft_leaf_pkg::payload_bits-1:0] res_data;
    logic [n_out-1:0] res_vld;
    logic [n_out-1:0] fire;
    logic [n_out-1:0][n_in-1:0] taken;
    logic [n_in-1:0] ack_next;
    logic [n_in-1:0] ack_q;

    always_comb begin
        res_next[0] = in_data[0] + in_data[1];
        res_next[1] = in_data[2] - in_data[3];
        res_next[2] = in_data[4] ^ in_data[5];
        res_next[3] = in_data[0] + in_data[5];
    end

    // A result fires when its slot is free and all of its inputs are fresh for it.
    always_comb begin
        for (int j = 0; j < n_out; j++) begin
            fire[j] = !res_vld[j] && ((in_vld & need[j]) == need[j])
                      && ((taken[j] & need[j]) == '0);
        end
    end

    // An input is released only once every result that reads it has taken it.
    always_comb begin
        for (int i = 0; i < n_in; i++) begin
            ack_next[i] = in_vld[i] && !ack_q[i];
            for (int j = 0; j < n_out; j++) begin
                if (need[j][i] && !(taken[j][i] || fire[j])) begin
                    ack_next[i] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_400) begin
        if (rst) begin
            res_vld <= '0;
            taken <= '0;
            ack_q <= '0;
        end else begin
            ack_q <= ack_next;
            for (int j = 0; j < n_out; j++) begin
                if (fire[j]) begin
                    res_vld[j] <= 1'b1;
                end else if (out_ack[j]) begin
                    res_vld[j] <= 1'b0;
                end
                for (int i = 0; i < n_in; i++) begin
                    if (ack_q[i]) begin
                        taken[j][i] <= 1'b0;
                    end else if (fire[j] && need[j][i]) begin
                        taken[j][i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_400) begin
        for (int j = 0; j < n_out; j++) begin
            if (fire[j]) begin
                res_data[j] <= res_next[j];
            end
        end
    end

    assign in_ack = ack_q;
    assign out_vld = res_vld;
    assign out_data = res_data;

endmodule

`default_nettype wire

// ==== logic/leaf_tx_encode.sv ====
`default_nettype none
`timescale 1ns/1ps

module leaf_tx_encode #(
    parameter logic [bft_leaf_pkg::leaf_bits-1:0] LEAF_ID = 2
) (
    input  logic                                                                   clk_400,
    input  logic                                                                   rst,
    input  logic                                                                   resend,
    input  bft_leaf_pkg::route_wr_t                                                route_wr,
    input  logic [bft_leaf_pkg::num_out_ports-1:0][bft_leaf_pkg::payload_bits-1:0] out_data,
    input  logic [bft_leaf_pkg::num_out_ports-1:0]                                 out_vld,
    output logic [bft_leaf_pkg::num_out_ports-1:0]                                 out_ack,
    output bft_leaf_pkg::packet_t                                                  dout
);

    localparam int n_out = bft_leaf_pkg::num_out_ports;
    localparam int sel_w = bft_leaf_pkg::sel_bits;
    localparam int port_w = bft_leaf_pkg::port_bits;

    bft_leaf_pkg::route_t [n_out-1:0] route_tab;
    bft_leaf_pkg::packet_t pkt;
    bft_leaf_pkg::packet_t dout_q;
    logic [sel_w-1:0] last_q;
    logic [sel_w-1:0] cand;
    logic [sel_w-1:0] gnt_idx;
    logic gnt_any;
    logic [n_out-1:0] gnt;

    // Round-robin search starts at the port after the last grant and ends on it.
    always_comb begin
        gnt_any = 1'b0;
        gnt_idx = last_q;
        cand = last_q;
        for (int k = 1; k <= n_out; k++) begin
            cand = last_q + sel_w'(k);
            if (!gnt_any && !resend && out_vld[cand]) begin
                gnt_any = 1'b1;
                gnt_idx = cand;
            end
        end
    end

    always_comb begin
        gnt = '0;
        gnt[gnt_idx] = gnt_any;
    end

    assign out_ack = gnt;

    // The source address is this leaf with the output index in the low bits.
    always_comb begin
        pkt.valid = 1'b1;
        pkt.dest_leaf = route_tab[gnt_idx].leaf;
        pkt.dest_port = route_tab[gnt_idx].port;
        pkt.addr = {LEAF_ID, gnt_idx};
        pkt.body.data = out_data[gnt_idx];
    end

    always_ff @(posedge clk_400) begin
        if (rst) begin
            last_q <= '1;
            dout_q <= '0;
            for (int i = 0; i < n_out; i++) begin
                route_tab[i].leaf <= LEAF_ID;
                route_tab[i].port <= port_w'(i + 1);
            end
        end else begin
            if (route_wr.wr) begin
                route_tab[route_wr.out_sel] <= route_wr.route;
            end
            // A packet caught by resend stays here and goes out once resend drops.
            if (!resend) begin
                if (gnt_any) begin
                    last_q <= gnt_idx;
                    dout_q <= pkt;
                end else begin
                    dout_q <= '0;
                end
            end
        end
    end

    assign dout = resend ? '0 : dout_q;

endmodule

`default_nettype wire

// ==== logic/leaf_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module leaf_top #(
    parameter logic [bft_leaf_pkg::leaf_bits-1:0] LEAF_ID = 2
) (
    input  logic                  clk_400,
    input  logic                  rst,
    input  bft_leaf_pkg::packet_t din,
    output bft_leaf_pkg::packet_t dout,
    input  logic                  resend
);

    localparam int n_in = bft_leaf_pkg::num_in_ports;
    localparam int n_out = bft_leaf_pkg::num_out_ports;
    localparam int w = bft_leaf_pkg::payload_bits;

    bft_leaf_pkg::port_word_t [n_in-1:0] port_words;
    bft_leaf_pkg::route_wr_t route_wr;

    logic [n_in-1:0][w-1:0] in_data;
    logic [n_in-1:0] in_vld;
    logic [n_in-1:0] in_ack;

    logic [n_out-1:0][w-1:0] out_data;
    logic [n_out-1:0] out_vld;
    logic [n_out-1:0] out_ack;

    leaf_rx_decode #(
        .LEAF_ID(LEAF_ID)
    ) u_rx (
        .clk_400(clk_400),
        .rst(rst),
        .din(din),
        .port_words(port_words),
        .route_wr(route_wr)
    );

    leaf_in_ports u_in (
        .clk_400(clk_400),
        .rst(rst),
        .port_words(port_words),
        .in_data(in_data),
        .in_vld(in_vld),
        .in_ack(in_ack)
    );

    leaf_user_kernel u_kernel (
        .clk_400(clk_400),
        .rst(rst),
        .in_data(in_data),
        .in_vld(in_vld),
        .in_ack(in_ack),
        .out_data(out_data),
        .out_vld(out_vld),
        .out_ack(out_ack)
    );

    leaf_tx_encode #(
        .LEAF_ID(LEAF_ID)
    ) u_tx (
        .clk_400(clk_400),
        .rst(rst),
        .resend(resend),
        .route_wr(route_wr),
        .out_data(out_data),
        .out_vld(out_vld),
        .out_ack(out_ack),
        .dout(dout)
    );

endmodule

`default_nettype wire

// ==== tests/leaf_props.sv ====
`default_nettype none
`timescale 1ns/1ps

module leaf_props (
    input logic                  clk_400,
    input logic                  rst,
    input logic [5:0]            wr_vld,
    input logic [5:0]            buf_full,
    input logic [3:0]            ack,
    input logic                  resend,
    input bft_leaf_pkg::packet_t dout
);

    // The tree has no back-pressure, so a word for a busy port would be lost.
    no_write_to_full: assert property (@(posedge clk_400) disable iff (rst)
        (wr_vld & buf_full) == 6'b0)
        else $error("data word written to an input port that still holds a word");

    one_ack: assert property (@(posedge clk_400) disable iff (rst) $onehot0(ack))
        else $error("more than one output port acknowledged in a cycle");

    no_ack_in_resend: assert property (@(posedge clk_400) disable iff (rst)
        resend |-> (ack == 4'b0))
        else $error("output port acknowledged while resend is high");

    dout_zero_in_resend: assert property (@(posedge clk_400) disable iff (rst)
        resend |-> (dout == '0))
        else $error("dout is not blank while resend is high");

endmodule

// The input buffer writes and the transmit acks meet in the top level.
bind leaf_top leaf_props u_leaf_props (
    .clk_400(clk_400),
    .rst(rst),
    .wr_vld({port_words[5].vld, port_words[4].vld, port_words[3].vld,
             port_words[2].vld, port_words[1].vld, port_words[0].vld}),
    .buf_full(in_vld),
    .ack(out_ack),
    .resend(resend),
    .dout(dout)
);

`default_nettype wire

// ==== tests/leaf_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module leaf_tb;

    localparam logic [4:0] leaf_id = 5'd2;
    localparam logic [4:0] other_leaf = 5'd9;
    localparam int n_cases = 5;
    localparam int wait_limit = 200;
    localparam int drain_cycles = 24;

    // Each cfg entry is {out_sel, route leaf, route port}; order lists data ports from entry 0.
    typedef struct packed {
        logic [1:0] n_cfg;
        logic [1:0][10:0] cfg;
        logic junk;
        logic [5:0][2:0] order;
        logic [3:0] gap;
        logic hold;
    } case_row_t;

    logic clk_400;
    logic rst;
    logic resend;
    bft_leaf_pkg::packet_t din;
    bft_leaf_pkg::packet_t dout;

    case_row_t rows [n_cases];
    string names [n_cases];
    bft_leaf_pkg::packet_t seen [$];
    int seen_in_resend;
    logic [4:0] route_leaf [4];
    logic [3:0] route_port [4];
    logic [31:0] words [6];
    logic [31:0] expect_body [4];
    int errors;
    int case_errors;
    int checks;
    int cases_run;
    int cases_passed;
    logic timed_out;

    leaf_top #(
        .LEAF_ID(leaf_id)
    ) u_leaf_top (
        .clk_400(clk_400),
        .rst(rst),
        .din(din),
        .dout(dout),
        .resend(resend)
    );

    initial clk_400 = 1'b0;
    always #2 clk_400 = ~clk_400;

    always @(negedge clk_400) begin
        if (!rst && dout.valid) begin
            seen.push_back(dout);
            if (resend) begin
                seen_in_resend++;
            end
        end
    end

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk_400);
            #0.5;
        end
    endtask

    task automatic send_packet(input bft_leaf_pkg::packet_t p);
        step(1);
        din = p;
        step(1);
        din = '0;
    endtask

    task automatic send_cfg(input logic [4:0] leaf, input logic [10:0] entry);
        bft_leaf_pkg::packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.dest_leaf = leaf;
        p.dest_port = bft_leaf_pkg::cfg_port;
        p.body.cfg.out_sel = entry[10:9];
        p.body.cfg.route_leaf = entry[8:4];
        p.body.cfg.route_port = entry[3:0];
        send_packet(p);
    endtask

    task automatic send_data(input logic [4:0] leaf, input logic [3:0] port,
                             input logic [31:0] word);
        bft_leaf_pkg::packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.dest_leaf = leaf;
        p.dest_port = port;
        p.body.data = word;
        send_packet(p);
    endtask

    // Only writes addressed to this leaf move the route model.
    task automatic apply_cfg(input logic [10:0] entry);
        send_cfg(leaf_id, entry);
        route_leaf[entry[10:9]] = entry[8:4];
        route_port[entry[10:9]] = entry[3:0];
    endtask

    task automatic send_junk();
        send_cfg(other_leaf, {2'd1, 5'd17, 4'd9});
        for (int p = 1; p <= 6; p++) begin
            send_data(other_leaf, 4'(p), $urandom());
        end
        for (int p = 7; p <= 15; p++) begin
            send_data(leaf_id, 4'(p), $urandom());
        end
    endtask

    task automatic wait_for_packets(input int count);
        int n;
        n = 0;
        while (seen.size() < count && n < wait_limit) begin
            step(1);
            n++;
        end
        if (seen.size() < count) begin
            $display("timeout: only %0d of %0d output packets arrived by t=%0t",
                     seen.size(), count, $time);
            timed_out = 1'b1;
            case_errors++;
        end
    endtask

    task automatic check_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("error: t=%0t %s expected %h got %h", $time, sig, exp, got);
            case_errors++;
        end
    endtask

    task automatic check_case();
        int hits;
        bft_leaf_pkg::packet_t match;
        logic [6:0] addr;
        check_value("dout packet count", 32'(seen.size()), 32'd4);
        check_value("dout.valid during resend", 32'(seen_in_resend), 32'd0);
        for (int k = 0; k < 4; k++) begin
            addr = {leaf_id, 2'(k)};
            hits = 0;
            match = '0;
            foreach (seen[i]) begin
                if (seen[i].addr == addr) begin
                    hits++;
                    match = seen[i];
                end
            end
            checks++;
            assert (hits == 1) else begin
                $display("output %0d produced %0d packets instead of one", k, hits);
                case_errors++;
            end
            if (hits > 0) begin
                check_value($sformatf("dout.dest_leaf[%0d]", k), 32'(match.dest_leaf),
                            32'(route_leaf[k]));
                check_value($sformatf("dout.dest_port[%0d]", k), 32'(match.dest_port),
                            32'(route_port[k]));
                check_value($sformatf("dout.body[%0d]", k), match.body.data, expect_body[k]);
            end
        end
    endtask

    task automatic run_case(input int idx);
        case_row_t row;
        int port;
        row = rows[idx];
        seen.delete();
        seen_in_resend = 0;
        case_errors = 0;
        for (int i = 0; i < 6; i++) begin
            words[i] = $urandom();
        end
        resend = row.hold;
        if (row.n_cfg > 2'd0) begin
            apply_cfg(row.cfg[0]);
        end
        if (row.n_cfg > 2'd1) begin
            apply_cfg(row.cfg[1]);
        end
        if (row.junk) begin
            send_junk();
        end
        for (int i = 0; i < 6; i++) begin
            if (i == 5) begin
                step(int'(row.gap));
            end
            port = int'(row.order[i]);
            send_data(leaf_id, 4'(port), words[port - 1]);
        end
        if (row.hold) begin
            step(12);
            resend = 1'b0;
        end
        // Kernel results, with inputs numbered from 1 as in the port numbers.
        expect_body[0] = words[0] + words[1];
        expect_body[1] = words[2] - words[3];
        expect_body[2] = words[4] ^ words[5];
        expect_body[3] = words[0] + words[5];
        wait_for_packets(4);
        step(drain_cycles);
        check_case();
        cases_run++;
        errors += case_errors;
        if (case_errors == 0) begin
            cases_passed++;
            $display("case %0d %s: passed", idx + 1, names[idx]);
        end else begin
            $display("case %0d %s: failed with %0d errors", idx + 1, names[idx], case_errors);
        end
    endtask

    initial begin
        void'($urandom(72));
        rst = 1'b1;
        resend = 1'b0;
        din = '0;
        errors = 0;
        checks = 0;
        cases_run = 0;
        cases_passed = 0;
        seen_in_resend = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 4; i++) begin
            route_leaf[i] = leaf_id;
            route_port[i] = 4'(i + 1);
        end
        names[0] = "loopback arithmetic";
        rows[0] = '{2'd0, 22'd0, 1'b0, 18'o654321, 4'd0, 1'b0};
        names[1] = "route rewrite";
        rows[1] = '{2'd2, {2'd2, 5'd20, 4'd6, 2'd0, 5'd11, 4'd3}, 1'b0, 18'o654321, 4'd0, 1'b0};
        names[2] = "address filter";
        rows[2] = '{2'd0, 22'd0, 1'b1, 18'o654321, 4'd0, 1'b0};
        names[3] = "resend hold";
        rows[3] = '{2'd0, 22'd0, 1'b0, 18'o123456, 4'd0, 1'b1};
        names[4] = "shared inputs";
        rows[4] = '{2'd0, 22'd0, 1'b0, 18'o615432, 4'd9, 1'b0};
        step(10);
        rst = 1'b0;
        step(4);
        for (int c = 0; c < n_cases && !timed_out; c++) begin
            run_case(c);
        end
        $display("cases %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 cases_run, cases_passed, cases_run - cases_passed, checks, errors);
        if (errors == 0 && cases_run == n_cases) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/bft_leaf_pkg.sv
logic/leaf_rx_decode.sv
logic/leaf_in_ports.sv
logic/leaf_user_kernel.sv
logic/leaf_tx_encode.sv
logic/leaf_top.sv
tests/leaf_props.sv
tests/leaf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the leaf testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module leaf_tb -f all.f -Mdir obj_dir -o leaf_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/leaf_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
